//--- build.f
design/sdctrl_pkg.sv
design/sd_cmd_if.sv
design/sdmode_init_seq.sv
design/cmd_req_fifo.sv
design/cmd_line_phy.sv
design/sdctrl_top.sv
verification/tb_sdctrl.sv

//--- design/cmd_line_phy.sv
module cmd_line_phy import sdctrl_pkg::*; (
    input logic i_clk,
    input logic i_nrst,
    input logic i_400khz_ena,
    sd_cmd_if.sink req,
    sd_resp_if.source resp,
    input logic i_cmd,
    output logic o_cmd,
    output logic o_cmd_dir,
    output logic o_sclk
);

typedef enum logic [1:0] {
    P_IDLE,
    P_TX,
    P_NCR,
    P_RX
} phy_state_e;

phy_state_e state;
logic [DIV_W-1:0] div_cnt;
logic [DIV_W-1:0] div_max;
logic [DIV_W-1:0] div_half;
logic div_fast;
logic fall_tick;
logic rise_tick;
logic [5:0] bit_cnt;
logic [NCR_W-1:0] ncr_cnt;
logic [39:0] tx_sr;
logic [6:0] tx_crc;
logic tx_bit;
logic [46:0] rx_sr;
logic [6:0] rx_crc;
logic [47:0] rx_frame;
sd_cmd_e cur_cmd;
sd_resp_e cur_rn;
logic accept;
logic tx_shift;
logic rx_shift;
logic crc_bad;
logic idx_bad;

// Serial clock, low phase first, high phase second
assign div_max = div_fast ? DIV_W'(SCLK_DIV_FAST - 1) : DIV_W'(SCLK_DIV_SLOW - 1);
assign div_half = div_fast ? DIV_W'(SCLK_DIV_FAST / 2 - 1) : DIV_W'(SCLK_DIV_SLOW / 2 - 1);
assign fall_tick = (div_cnt == div_max);
assign rise_tick = (div_cnt == div_half);

assign req.ready = (state == P_IDLE);
assign accept = req.valid && (state == P_IDLE);
assign tx_shift = (state == P_TX) && fall_tick && (bit_cnt != 6'd48);
assign rx_shift = rise_tick && ((state == P_NCR && !i_cmd) || state == P_RX);

// Start and transmission bits, index and argument, then CRC7, then end bit
assign tx_bit = (bit_cnt < 6'd40) ? tx_sr[39] : (bit_cnt < 6'd47) ? tx_crc[6] : 1'b1;

// Complete response frame at the sample of its last bit
assign rx_frame = {rx_sr, i_cmd};
// R3 carries all ones in place of a CRC
assign crc_bad = (cur_rn != R3) && (rx_frame[7:1] != rx_crc);
assign idx_bad = (cur_rn == R2 || cur_rn == R3) ? (rx_frame[45:40] != 6'h3F)
                                                : (rx_frame[45:40] != cur_cmd);

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        div_cnt <= '0;
        div_fast <= 1'b0;
        o_sclk <= 1'b0;
    end else if (fall_tick) begin
        div_cnt <= '0;
        o_sclk <= 1'b0;
        // Rate only changes between frames
        if (state == P_IDLE) begin
            div_fast <= ~i_400khz_ena;
        end
    end else begin
        div_cnt <= div_cnt + 1'b1;
        if (rise_tick) begin
            o_sclk <= 1'b1;
        end
    end
end

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state <= P_IDLE;
        bit_cnt <= 6'd0;
        ncr_cnt <= '0;
        o_cmd <= 1'b1;
        o_cmd_dir <= 1'b1;
        resp.valid <= 1'b0;
        resp.cmd <= CMD0;
        resp.arg <= 32'd0;
        resp.err <= ERR_NONE;
    end else begin
        resp.valid <= 1'b0;
        case (state)
        P_IDLE: begin
            if (accept) begin
                state <= P_TX;
                bit_cnt <= 6'd0;
                o_cmd_dir <= 1'b0;
            end
        end
        P_TX: begin
            if (fall_tick) begin
                if (bit_cnt == 6'd48) begin
                    o_cmd <= 1'b1;
                    o_cmd_dir <= 1'b1;
                    ncr_cnt <= '0;
                    if (cur_rn == R_NONE) begin
                        state <= P_IDLE;
                        resp.valid <= 1'b1;
                        resp.cmd <= cur_cmd;
                        resp.arg <= 32'd0;
                        resp.err <= ERR_NONE;
                    end else begin
                        state <= P_NCR;
                    end
                end else begin
                    o_cmd <= tx_bit;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
        P_NCR: begin
            if (rise_tick) begin
                if (!i_cmd) begin
                    state <= P_RX;
                    bit_cnt <= 6'd1;
                end else if (ncr_cnt == NCR_W'(NCR_MAX - 1)) begin
                    state <= P_IDLE;
                    resp.valid <= 1'b1;
                    resp.cmd <= cur_cmd;
                    resp.arg <= 32'd0;
                    resp.err <= ERR_NO_RESPONSE;
                end else begin
                    ncr_cnt <= ncr_cnt + 1'b1;
                end
            end
        end
        default: begin
            if (rise_tick) begin
                if (bit_cnt == 6'd47) begin
                    state <= P_IDLE;
                    resp.valid <= 1'b1;
                    resp.cmd <= cur_cmd;
                    resp.arg <= rx_frame[39:8];
                    resp.err <= crc_bad ? ERR_CRC : idx_bad ? ERR_BAD_INDEX : ERR_NONE;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (accept) begin
        tx_sr <= {2'b01, req.cmd, req.arg};
        tx_crc <= 7'd0;
        rx_crc <= 7'd0;
        cur_cmd <= req.cmd;
        cur_rn <= req.rn;
    end else if (tx_shift) begin
        if (bit_cnt < 6'd40) begin
            tx_sr <= {tx_sr[38:0], 1'b0};
            tx_crc <= crc7_next(tx_crc, tx_sr[39]);
        end else begin
            tx_crc <= {tx_crc[5:0], 1'b0};
        end
    end
    if (rx_shift) begin
        rx_sr <= {rx_sr[45:0], i_cmd};
        // Start bit is sampled in P_NCR and belongs to the CRC
        if (state == P_NCR || bit_cnt < 6'd40) begin
            rx_crc <= crc7_next(rx_crc, i_cmd);
        end
    end
end

// Host owns the line for the whole frame
a_dir_during_tx: assert property (@(posedge i_clk) disable iff (!i_nrst)
    (state == P_TX) |-> !o_cmd_dir);

endmodule: cmd_line_phy

//--- design/cmd_req_fifo.sv
module cmd_req_fifo import sdctrl_pkg::*; (
    input logic i_clk,
    input logic i_nrst,
    sd_cmd_if.sink wr,
    sd_cmd_if.source rd
);

sd_cmd_e cmd_mem [2];
logic [31:0] arg_mem [2];
sd_resp_e rn_mem [2];
logic wr_ptr;
logic rd_ptr;
logic [1:0] count;
logic push;
logic pop;

assign push = wr.valid && wr.ready;
assign pop = rd.valid && rd.ready;

assign wr.ready = (count != 2'd2);
assign rd.valid = (count != 2'd0);
assign rd.cmd = cmd_mem[rd_ptr];
assign rd.arg = arg_mem[rd_ptr];
assign rd.rn = rn_mem[rd_ptr];

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        wr_ptr <= 1'b0;
        rd_ptr <= 1'b0;
        count <= 2'd0;
    end else begin
        if (push) begin
            wr_ptr <= ~wr_ptr;
        end
        if (pop) begin
            rd_ptr <= ~rd_ptr;
        end
        count <= count + {1'b0, push} - {1'b0, pop};
    end
end

always_ff @(posedge i_clk) begin
    if (push) begin
        cmd_mem[wr_ptr] <= wr.cmd;
        arg_mem[wr_ptr] <= wr.arg;
        rn_mem[wr_ptr] <= wr.rn;
    end
end

// A request refused by the full FIFO stays offered unchanged
a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
    (wr.valid && !wr.ready) |=> (wr.valid && $stable(wr.cmd) && $stable(wr.arg)
                                 && $stable(wr.rn)));

// Head entry stays put until the phy takes it
a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
    (rd.valid && !rd.ready) |=> (rd.valid && $stable(rd.cmd) && $stable(rd.arg)
                                 && $stable(rd.rn)));

endmodule: cmd_req_fifo

//--- design/sd_cmd_if.sv
// Command request, valid/ready handshake
interface sd_cmd_if import sdctrl_pkg::*; ();

logic valid;
logic ready;
sd_cmd_e cmd;
logic [31:0] arg;
sd_resp_e rn;

modport source (output valid, output cmd, output arg, output rn, input ready);
modport sink (input valid, input cmd, input arg, input rn, output ready);

endinterface: sd_cmd_if

// Command response, single-cycle pulse without back-pressure
interface sd_resp_if import sdctrl_pkg::*; ();

logic valid;
sd_cmd_e cmd;
logic [31:0] arg;
sd_err_e err;

modport source (output valid, output cmd, output arg, output err);
modport sink (input valid, input cmd, input arg, input err);

endinterface: sd_resp_if

//--- design/sdctrl_pkg.sv
package sdctrl_pkg;

// Command indexes as they appear in the 6-bit index field
typedef enum logic [5:0] {
    CMD0   = 6'd0,
    CMD2   = 6'd2,
    CMD3   = 6'd3,
    CMD8   = 6'd8,
    CMD11  = 6'd11,
    ACMD41 = 6'd41,
    CMD55  = 6'd55
} sd_cmd_e;

typedef enum logic [2:0] {
    R_NONE,
    R1,
    R2,
    R3,
    R6,
    R7
} sd_resp_e;

typedef enum logic [1:0] {
    ERR_NONE,
    ERR_NO_RESPONSE,
    ERR_CRC,
    ERR_BAD_INDEX
} sd_err_e;

typedef enum logic [1:0] {
    SDCARD_UNKNOWN,
    SDCARD_VER1X,
    SDCARD_VER2X_SC,
    SDCARD_VER2X_HC
} sd_type_e;

typedef enum logic [3:0] {
    ST_CMD0,
    ST_CMD8,
    ST_CMD55,
    ST_ACMD41,
    ST_CHECK_OCR,
    ST_CMD11,
    ST_CMD2,
    ST_CMD3,
    ST_STBY,
    ST_WAIT
} init_state_e;

// i_clk cycles per serial bit
localparam int SCLK_DIV_SLOW = 8;
localparam int SCLK_DIV_FAST = 2;
// Bit times allowed before the response start bit
localparam int NCR_MAX = 64;
localparam int ACMD41_RETRY_MAX = 8;
// 2.7 V to 3.6 V window of the OCR
localparam logic [23:0] VOLTAGE_WINDOW = 24'hFF8000;

localparam int DIV_W = $clog2(SCLK_DIV_SLOW);
localparam int NCR_W = $clog2(NCR_MAX);
localparam int RETRY_W = $clog2(ACMD41_RETRY_MAX);

// One serial step of CRC7, g(x) = x^7 + x^3 + 1
function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
    logic fb;
    fb = din ^ crc[6];
    return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
endfunction

endpackage: sdctrl_pkg

//--- design/sdctrl_top.sv
module sdctrl_top import sdctrl_pkg::*; (
    input logic i_clk,
    input logic i_nrst,
    input logic i_cmd,
    input logic [3:0] i_cfg_voltage_supply,
    input logic [7:0] i_cfg_check_pattern,
    output logic o_cmd,
    output logic o_cmd_dir,
    output logic o_sclk,
    output logic [1:0] o_sdtype,
    output logic [15:0] o_rca,
    output logic o_s18,
    output logic o_init_done,
    output logic o_init_err
);

sd_cmd_if seq_req();
sd_cmd_if phy_req();
sd_resp_if cmd_resp();

sd_type_e sdtype;
logic slow_clk_ena;

assign o_sdtype = sdtype;

sdmode_init_seq u_init_seq (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .i_cfg_voltage_supply(i_cfg_voltage_supply),
    .i_cfg_check_pattern(i_cfg_check_pattern),
    .req(seq_req.source),
    .resp(cmd_resp.sink),
    .o_sdtype(sdtype),
    .o_rca(o_rca),
    .o_s18(o_s18),
    .o_400khz_ena(slow_clk_ena),
    .o_init_done(o_init_done),
    .o_init_err(o_init_err)
);

cmd_req_fifo u_req_fifo (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .wr(seq_req.sink),
    .rd(phy_req.source)
);

cmd_line_phy u_cmd_phy (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .i_400khz_ena(slow_clk_ena),
    .req(phy_req.sink),
    .resp(cmd_resp.source),
    .i_cmd(i_cmd),
    .o_cmd(o_cmd),
    .o_cmd_dir(o_cmd_dir),
    .o_sclk(o_sclk)
);

endmodule: sdctrl_top

//--- design/sdmode_init_seq.sv
module sdmode_init_seq import sdctrl_pkg::*; (
    input logic i_clk,
    input logic i_nrst,
    input logic [3:0] i_cfg_voltage_supply,
    input logic [7:0] i_cfg_check_pattern,
    sd_cmd_if.source req,
    sd_resp_if.sink resp,
    output sd_type_e o_sdtype,
    output logic [15:0] o_rca,
    output logic o_s18,
    output logic o_400khz_ena,
    output logic o_init_done,
    output logic o_init_err
);

init_state_e state;
init_state_e next_state;
logic hcs;
// Power-up done, CCS and S18A taken from the last R3
logic [2:0] ocr_bits;
logic [RETRY_W-1:0] retry_cnt;

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state <= ST_CMD0;
        next_state <= ST_CMD0;
        hcs <= 1'b1;
        ocr_bits <= 3'd0;
        retry_cnt <= '0;
        req.valid <= 1'b0;
        req.cmd <= CMD0;
        req.arg <= 32'd0;
        req.rn <= R_NONE;
        o_sdtype <= SDCARD_UNKNOWN;
        o_rca <= 16'd0;
        o_s18 <= 1'b0;
        o_400khz_ena <= 1'b1;
        o_init_done <= 1'b0;
        o_init_err <= 1'b0;
    end else if (!o_init_err) begin
        case (state)
        ST_CMD0: begin
            // GO_IDLE_STATE gets no response
            req.valid <= 1'b1;
            req.cmd <= CMD0;
            req.arg <= 32'd0;
            req.rn <= R_NONE;
            next_state <= ST_CMD8;
            state <= ST_WAIT;
        end
        ST_CMD8: begin
            req.valid <= 1'b1;
            req.cmd <= CMD8;
            req.arg <= {20'd0, i_cfg_voltage_supply, i_cfg_check_pattern};
            req.rn <= R7;
            next_state <= ST_CMD55;
            state <= ST_WAIT;
        end
        ST_CMD55: begin
            req.valid <= 1'b1;
            req.cmd <= CMD55;
            req.arg <= 32'd0;
            req.rn <= R1;
            next_state <= ST_ACMD41;
            state <= ST_WAIT;
        end
        ST_ACMD41: begin
            // HCS in bit 30, S18R in bit 24
            req.valid <= 1'b1;
            req.cmd <= ACMD41;
            req.arg <= {1'b0, hcs, 5'd0, 1'b1, VOLTAGE_WINDOW};
            req.rn <= R3;
            next_state <= ST_CHECK_OCR;
            state <= ST_WAIT;
        end
        ST_CHECK_OCR: begin
            if (!ocr_bits[2]) begin
                // Card still busy with power-up
                if (retry_cnt == RETRY_W'(ACMD41_RETRY_MAX - 1)) begin
                    o_init_err <= 1'b1;
                end else begin
                    retry_cnt <= retry_cnt + 1'b1;
                    state <= ST_CMD55;
                end
            end else begin
                if (ocr_bits[1]) begin
                    o_sdtype <= SDCARD_VER2X_HC;
                end else if (o_sdtype != SDCARD_VER1X) begin
                    o_sdtype <= SDCARD_VER2X_SC;
                end
                o_s18 <= ocr_bits[0];
                state <= ocr_bits[0] ? ST_CMD11 : ST_CMD2;
            end
        end
        ST_CMD11: begin
            req.valid <= 1'b1;
            req.cmd <= CMD11;
            req.arg <= 32'd0;
            req.rn <= R1;
            next_state <= ST_CMD2;
            state <= ST_WAIT;
        end
        ST_CMD2: begin
            req.valid <= 1'b1;
            req.cmd <= CMD2;
            req.arg <= 32'd0;
            req.rn <= R2;
            next_state <= ST_CMD3;
            state <= ST_WAIT;
        end
        ST_CMD3: begin
            req.valid <= 1'b1;
            req.cmd <= CMD3;
            req.arg <= 32'd0;
            req.rn <= R6;
            next_state <= ST_STBY;
            state <= ST_WAIT;
        end
        ST_WAIT: begin
            if (req.valid && req.ready) begin
                req.valid <= 1'b0;
            end
            if (resp.valid) begin
                state <= next_state;
                case (req.cmd)
                CMD8: begin
                    // Silent card is a version 1.x card, no high capacity
                    if (resp.err == ERR_NO_RESPONSE) begin
                        o_sdtype <= SDCARD_VER1X;
                        hcs <= 1'b0;
                    end
                end
                ACMD41: begin
                    if (resp.err == ERR_NONE) begin
                        ocr_bits <= {resp.arg[31:30], resp.arg[24]};
                    end else begin
                        ocr_bits <= 3'd0;
                    end
                end
                CMD2: begin
                    if (resp.err != ERR_NONE) begin
                        o_init_err <= 1'b1;
                    end
                end
                CMD3: begin
                    if (resp.err != ERR_NONE) begin
                        o_init_err <= 1'b1;
                    end else begin
                        o_rca <= resp.arg[31:16];
                        o_init_done <= 1'b1;
                        o_400khz_ena <= 1'b0;
                    end
                end
                default: begin
                end
                endcase
            end
        end
        default: begin
            // Standby, nothing more to issue
        end
        endcase
    end
end

// Only one command in flight, a new request follows the previous response
a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_nrst)
    ($rose(req.valid) && req.cmd != CMD0) |-> ($past(resp.valid, 2) || $past(resp.valid, 3)));

endmodule: sdmode_init_seq

//--- run_sim.sh
#!/bin/sh
# Build the SD command-path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_sdctrl -o sim_sdctrl
./obj_dir/sim_sdctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    exit 1
fi

//--- verification/tb_sdctrl.sv
module tb_sdctrl import sdctrl_pkg::*; ();

localparam int CLK_PERIOD = 4;
localparam int TIMEOUT_CYCLES = 6 * 20 * 120 * SCLK_DIV_SLOW;
localparam logic [3:0] VOLTAGE_SUPPLY = 4'h1;

// How the card model answers one command index
typedef enum int {
    ANS_NONE,
    ANS_OK,
    ANS_BAD_CRC
} answer_e;

logic i_clk;
logic i_nrst;
logic i_cmd;
logic [3:0] i_cfg_voltage_supply;
logic [7:0] i_cfg_check_pattern;
logic o_cmd;
logic o_cmd_dir;
logic o_sclk;
logic [1:0] o_sdtype;
logic [15:0] o_rca;
logic o_s18;
logic o_init_done;
logic o_init_err;

// Card script of the running test
answer_e ans_mode [64];
int busy_left;
int card_busy;
logic card_ccs;
logic card_s18a;
logic [15:0] card_rca;
logic [7:0] check_pattern;

// Expected command list and final outputs
logic [5:0] exp_cmd [$];
logic [31:0] exp_arg [$];
sd_type_e exp_type;
logic [15:0] exp_rca;
logic exp_s18;
logic exp_done;
logic exp_err;

logic [47:0] frame_q [$];
int frame_idx;
string test_name;
int test_errs;
int pass_cnt;
int fail_cnt;
int cycle_cnt;
int seed;

sdctrl_top UUT (
    .i_clk(i_clk),
    .i_nrst(i_nrst),
    .i_cmd(i_cmd),
    .i_cfg_voltage_supply(i_cfg_voltage_supply),
    .i_cfg_check_pattern(i_cfg_check_pattern),
    .o_cmd(o_cmd),
    .o_cmd_dir(o_cmd_dir),
    .o_sclk(o_sclk),
    .o_sdtype(o_sdtype),
    .o_rca(o_rca),
    .o_s18(o_s18),
    .o_init_done(o_init_done),
    .o_init_err(o_init_err)
);

initial begin
    i_clk = 1'b0;
    forever begin
        #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end
end

always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout in %s: initialization did not finish within %0d clock cycles",
                 test_name, TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end
end

// Bit-serial CRC7 over the first 40 bits of a frame, g(x) = x^7 + x^3 + 1
function automatic logic [6:0] crc7_ref(input logic [39:0] d);
    logic [6:0] c;
    logic fb;
    c = 7'd0;
    for (int i = 39; i >= 0; i--) begin
        fb = d[i] ^ c[6];
        c = {c[5:0], 1'b0};
        if (fb) begin
            c = c ^ 7'h09;
        end
    end
    return c;
endfunction

function automatic void push_expected(input logic [5:0] cmd, input logic [31:0] arg);
    exp_cmd.push_back(cmd);
    exp_arg.push_back(arg);
endfunction

// Command list and final outputs that the card script should produce
function automatic void build_expected();
    logic hcs;
    exp_cmd.delete();
    exp_arg.delete();
    exp_type = SDCARD_UNKNOWN;
    exp_rca = 16'd0;
    exp_s18 = 1'b0;
    exp_done = 1'b0;
    exp_err = 1'b0;
    hcs = 1'b1;
    push_expected(CMD0, 32'd0);
    push_expected(CMD8, {20'd0, VOLTAGE_SUPPLY, check_pattern});
    if (ans_mode[CMD8] == ANS_NONE) begin
        exp_type = SDCARD_VER1X;
        hcs = 1'b0;
    end
    for (int attempt = 1; attempt <= ACMD41_RETRY_MAX; attempt++) begin
        push_expected(CMD55, 32'd0);
        push_expected(ACMD41, {1'b0, hcs, 5'd0, 1'b1, VOLTAGE_WINDOW});
        if (attempt > card_busy) begin
            break;
        end
    end
    if (card_busy >= ACMD41_RETRY_MAX) begin
        exp_err = 1'b1;
        return;
    end
    if (card_ccs) begin
        exp_type = SDCARD_VER2X_HC;
    end else if (exp_type != SDCARD_VER1X) begin
        exp_type = SDCARD_VER2X_SC;
    end
    exp_s18 = card_s18a;
    if (card_s18a) begin
        push_expected(CMD11, 32'd0);
    end
    push_expected(CMD2, 32'd0);
    if (ans_mode[CMD2] != ANS_OK) begin
        exp_err = 1'b1;
        return;
    end
    push_expected(CMD3, 32'd0);
    if (ans_mode[CMD3] != ANS_OK) begin
        exp_err = 1'b1;
        return;
    end
    exp_rca = card_rca;
    exp_done = 1'b1;
endfunction

// Card side answer to one received frame
task automatic respond(input logic [47:0] f);
    logic [5:0] ridx;
    logic [31:0] rarg;
    logic [6:0] rcrc;
    logic [47:0] r;
    ridx = f[45:40];
    rarg = 32'h0000_0120;
    if (ridx == CMD0 || ans_mode[ridx] == ANS_NONE) begin
        return;
    end
    case (ridx)
    CMD8: rarg = f[39:8];
    ACMD41: begin
        rarg = {(busy_left == 0), card_ccs, 5'd0, card_s18a, VOLTAGE_WINDOW};
        if (busy_left > 0) begin
            busy_left--;
        end
    end
    CMD3: rarg = {card_rca, 16'h0500};
    default: begin
    end
    endcase
    // R2 and R3 carry the reserved index
    if (ridx == CMD2 || ridx == ACMD41) begin
        ridx = 6'h3F;
    end
    rcrc = (f[45:40] == ACMD41) ? 7'h7F : crc7_ref({2'b00, ridx, rarg});
    if (ans_mode[f[45:40]] == ANS_BAD_CRC) begin
        rcrc = rcrc ^ 7'h01;
    end
    r = {2'b00, ridx, rarg, rcrc, 1'b1};
    repeat (2) @(negedge o_sclk);
    for (int i = 47; i >= 0; i--) begin
        i_cmd <= r[i];
        @(negedge o_sclk);
    end
    i_cmd <= 1'b1;
endtask

initial begin : card_model
    logic [47:0] frame;
    i_cmd = 1'b1;
    forever begin
        @(posedge o_sclk);
        if (!o_cmd_dir && !o_cmd) begin
            frame = 48'd0;
            for (int i = 46; i >= 0; i--) begin
                @(posedge o_sclk);
                frame[i] = o_cmd;
            end
            frame_q.push_back(frame);
            respond(frame);
        end
    end
end

always @(posedge i_clk) begin : compare_frames
    logic [47:0] f;
    if (frame_q.size() != 0) begin
        f = frame_q.pop_front();
        assert (f[47] == 1'b0 && f[46] == 1'b1 && f[0] == 1'b1) else begin
            $display("** Error %s: frame framing bits expected 011 actual %b%b%b",
                     test_name, f[47], f[46], f[0]);
            test_errs++;
        end
        assert (f[7:1] == crc7_ref(f[47:8])) else begin
            $display("** Error %s: frame CRC7 expected %h actual %h",
                     test_name, crc7_ref(f[47:8]), f[7:1]);
            test_errs++;
        end
        assert (frame_idx < exp_cmd.size()) else begin
            $display("%s: the controller sent an unexpected extra command, index %0d",
                     test_name, f[45:40]);
            test_errs++;
        end
        if (frame_idx < exp_cmd.size()) begin
            assert (f[45:40] == exp_cmd[frame_idx]) else begin
                $display("** Error %s: command %0d index expected %0d actual %0d",
                         test_name, frame_idx, exp_cmd[frame_idx], f[45:40]);
                test_errs++;
            end
            assert (f[39:8] == exp_arg[frame_idx]) else begin
                $display("** Error %s: command %0d arg expected %h actual %h",
                         test_name, frame_idx, exp_arg[frame_idx], f[39:8]);
                test_errs++;
            end
        end
        frame_idx++;
    end
end

task automatic run_test(input string name, input answer_e cmd8_mode, input int busy,
                        input logic ccs, input logic s18a, input answer_e cmd3_mode,
                        input logic check_rate);
    time t0;
    time t1;
    int period;
    test_name = name;
    test_errs = 0;
    frame_idx = 0;
    for (int i = 0; i < 64; i++) begin
        ans_mode[i] = ANS_OK;
    end
    ans_mode[CMD0] = ANS_NONE;
    ans_mode[CMD8] = cmd8_mode;
    ans_mode[CMD3] = cmd3_mode;
    card_busy = busy;
    busy_left = busy;
    card_ccs = ccs;
    card_s18a = s18a;
    card_rca = 16'($random(seed));
    check_pattern = 8'($random(seed));
    build_expected();
    @(posedge i_clk);
    i_nrst <= 1'b0;
    i_cfg_check_pattern <= check_pattern;
    repeat (2) @(posedge i_clk);
    i_nrst <= 1'b1;
    @(posedge i_clk);
    while (!(o_init_done || o_init_err)) begin
        @(posedge i_clk);
    end
    // Let the card finish driving and release the line
    repeat (4) @(negedge o_sclk);
    assert (o_sdtype == exp_type) else begin
        $display("** Error %s: o_sdtype expected %0d actual %0d", name, exp_type, o_sdtype);
        test_errs++;
    end
    assert (o_rca == exp_rca) else begin
        $display("** Error %s: o_rca expected %h actual %h", name, exp_rca, o_rca);
        test_errs++;
    end
    assert (o_s18 == exp_s18) else begin
        $display("** Error %s: o_s18 expected %b actual %b", name, exp_s18, o_s18);
        test_errs++;
    end
    assert (o_init_done == exp_done && o_init_err == exp_err) else begin
        $display("** Error %s: done/err expected %b%b actual %b%b",
                 name, exp_done, exp_err, o_init_done, o_init_err);
        test_errs++;
    end
    // Idle host leaves the CMD line released and high
    assert (o_cmd_dir == 1'b1 && o_cmd == 1'b1) else begin
        $display("** Error %s: o_cmd_dir/o_cmd expected 11 actual %b%b",
                 name, o_cmd_dir, o_cmd);
        test_errs++;
    end
    assert (frame_idx == exp_cmd.size()) else begin
        $display("** Error %s: command count expected %0d actual %0d",
                 name, exp_cmd.size(), frame_idx);
        test_errs++;
    end
    if (check_rate) begin
        // Serial clock period in standby, averaged over four cycles
        @(posedge o_sclk);
        t0 = $time;
        repeat (4) @(posedge o_sclk);
        t1 = $time;
        period = int'((t1 - t0) / (4 * CLK_PERIOD));
        assert (period == SCLK_DIV_FAST) else begin
            $display("** Error %s: o_sclk period expected %0d actual %0d",
                     name, SCLK_DIV_FAST, period);
            test_errs++;
        end
    end
    if (test_errs == 0) begin
        pass_cnt++;
        $display("PASS %s", name);
    end else begin
        fail_cnt++;
        $display("FAIL %s with %0d errors", name, test_errs);
    end
endtask

initial begin
    seed = 45;
    i_nrst = 1'b0;
    i_cfg_voltage_supply = VOLTAGE_SUPPLY;
    i_cfg_check_pattern = 8'hAA;
    test_name = "reset";
    pass_cnt = 0;
    fail_cnt = 0;
    cycle_cnt = 0;
    run_test("frame_format", ANS_OK, 1, 1'b0, 1'b0, ANS_OK, 1'b0);
    run_test("hc_card", ANS_OK, 0, 1'b1, 1'b0, ANS_OK, 1'b1);
    run_test("ver1x_card", ANS_NONE, 0, 1'b0, 1'b0, ANS_OK, 1'b0);
    run_test("busy_exhaust", ANS_OK, 10, 1'b1, 1'b0, ANS_OK, 1'b0);
    run_test("s18_switch", ANS_OK, 3, 1'b1, 1'b1, ANS_OK, 1'b0);
    run_test("cmd3_bad_crc", ANS_OK, 0, 1'b1, 1'b0, ANS_BAD_CRC, 1'b0);
    $display("Tests run: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt,
             fail_cnt);
    if (fail_cnt == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule: tb_sdctrl
